/* all.f */
hw/alu_pkg.sv
hw/alu_decode.sv
hw/alu_adder.sv
hw/alu_shifter.sv
hw/alu_compare.sv
hw/alu_result.sv
hw/alu_top.sv
test/alu_props.sv
test/alu_tb.sv

/* test/alu_tb.sv */
// ALU testbench: clock, reset, four-phase request driver
// behavioral lane model, per-test lines and closing summary
`timescale 1ns/10ps

module alu_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int RESET_CYC   = 8;
  // logic 18, add/sub 28, shift/rotate 40, compare 72, min/max/abs 45
  localparam int NUM_TXN     = 203;
  localparam int TIMEOUT_CYC = NUM_TXN * 8 + RESET_CYC + 100;
  localparam int ACK_WAIT    = 10;

  logic              clk;
  logic              reset_i;
  logic              req_i;
  alu_pkg::alu_req_t req_data_i;
  logic              ack_o;
  alu_pkg::alu_rsp_t rsp_o;

  int    test_checks;
  int    test_errors;
  int    total_checks;
  int    total_errors;
  int    num_tests;
  string test_name;

  alu_pkg::vec_mode_e modes[3] = '{alu_pkg::VEC_MODE32, alu_pkg::VEC_MODE16, alu_pkg::VEC_MODE8};
  // most negative lane value for each entry of modes
  logic [31:0] most_neg[3] = '{32'h8000_0000, 32'h8000_8000, 32'h8080_8080};
  alu_pkg::alu_op_e logic_ops[] = '{alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR};
  alu_pkg::alu_op_e add_ops[]   = '{alu_pkg::ALU_ADD, alu_pkg::ALU_SUB};
  alu_pkg::alu_op_e shift_ops[] = '{alu_pkg::ALU_SLL, alu_pkg::ALU_SRL, alu_pkg::ALU_SRA};
  alu_pkg::alu_op_e cmp_ops[]   = '{alu_pkg::ALU_EQ, alu_pkg::ALU_NE, alu_pkg::ALU_LTS,
                                    alu_pkg::ALU_LTU, alu_pkg::ALU_GES, alu_pkg::ALU_GEU,
                                    alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU};
  alu_pkg::alu_op_e mm_ops[]    = '{alu_pkg::ALU_MIN, alu_pkg::ALU_MINU, alu_pkg::ALU_MAX,
                                    alu_pkg::ALU_MAXU, alu_pkg::ALU_ABS};

  alu_top DUT (
    .clk        (clk),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // hard stop if a handshake hangs
  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("watchdog expired, run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic bit is_cmp(input alu_pkg::alu_op_e op);
    return op inside {alu_pkg::ALU_EQ, alu_pkg::ALU_NE, alu_pkg::ALU_LTS, alu_pkg::ALU_LTU,
                      alu_pkg::ALU_GES, alu_pkg::ALU_GEU, alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU};
  endfunction

  function automatic alu_pkg::alu_rsp_t model(input alu_pkg::alu_req_t rq);
    alu_pkg::alu_rsp_t exp_rsp;
    bit                scalar;
    int                w;
    int                amt;
    longint unsigned   mask;
    longint unsigned   la;
    longint unsigned   lb;
    longint unsigned   lr;
    longint unsigned   acc;
    longint            sa;
    longint            sb;
    logic              hit;
    scalar = rq.op inside {alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU};
    acc    = 0;
    hit    = 1'b0;
    case (rq.mode)
      alu_pkg::VEC_MODE16: w = 16;
      alu_pkg::VEC_MODE8:  w = 8;
      default:             w = 32;
    endcase
    // set-less-than always looks at the whole word
    if (scalar) begin
      w = 32;
    end
    mask = (64'd1 << w) - 1;
    for (int i = 0; i < 32 / w; i++) begin
      la  = (rq.operand_a >> (i * w)) & mask;
      lb  = (rq.operand_b >> (i * w)) & mask;
      sa  = la[w-1] ? longint'(la) - longint'(64'd1 << w) : longint'(la);
      sb  = lb[w-1] ? longint'(lb) - longint'(64'd1 << w) : longint'(lb);
      amt = int'(lb % w);
      lr  = 0;
      case (rq.op)
        alu_pkg::ALU_AND:  lr = la & lb;
        alu_pkg::ALU_OR:   lr = la | lb;
        alu_pkg::ALU_XOR:  lr = la ^ lb;
        alu_pkg::ALU_ADD:  lr = la + lb;
        alu_pkg::ALU_SUB:  lr = la - lb;
        alu_pkg::ALU_SLL:  lr = la << amt;
        alu_pkg::ALU_SRL:  lr = la >> amt;
        alu_pkg::ALU_SRA:  lr = sa >>> amt;
        alu_pkg::ALU_ROR:  lr = (la >> amt) | (la << (w - amt));
        alu_pkg::ALU_EQ:   hit = (la == lb);
        alu_pkg::ALU_NE:   hit = (la != lb);
        alu_pkg::ALU_LTS, alu_pkg::ALU_SLTS: hit = (sa < sb);
        alu_pkg::ALU_LTU, alu_pkg::ALU_SLTU: hit = (la < lb);
        alu_pkg::ALU_GES:  hit = (sa >= sb);
        alu_pkg::ALU_GEU:  hit = (la >= lb);
        alu_pkg::ALU_MIN:  lr = (sa <= sb) ? la : lb;
        alu_pkg::ALU_MINU: lr = (la <= lb) ? la : lb;
        alu_pkg::ALU_MAX:  lr = (sa >= sb) ? la : lb;
        alu_pkg::ALU_MAXU: lr = (la >= lb) ? la : lb;
        // most negative value negates to itself
        alu_pkg::ALU_ABS:  lr = (sa < 0) ? (0 - la) : la;
        default:           lr = 0;
      endcase
      if (scalar) begin
        lr = hit;
      end else if (is_cmp(rq.op)) begin
        lr = hit ? mask : 0;
      end
      acc |= (lr & mask) << (i * w);
    end
    exp_rsp.result   = acc[31:0];
    // last lane visited is the top lane
    exp_rsp.cmp_flag = hit;
    return exp_rsp;
  endfunction

  ////////////////////
  // driver
  ////////////////////

  task automatic run_txn(input alu_pkg::alu_op_e op, input alu_pkg::vec_mode_e mode,
                         input logic [31:0] a, input logic [31:0] b);
    alu_pkg::alu_req_t rq;
    alu_pkg::alu_rsp_t exp_rsp;
    string             tag;
    int                waited;
    rq.op        = op;
    rq.mode      = mode;
    rq.operand_a = a;
    rq.operand_b = b;
    exp_rsp      = model(rq);
    tag          = $sformatf("%s %s %s", test_name, op.name(), mode.name());
    req_data_i   = rq;
    req_i        = 1'b1;
    waited       = 0;
    while (!ack_o && waited < ACK_WAIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!ack_o) begin
      $display("%s: ack_o never rose after req_i", tag);
      test_errors++;
    end
    test_checks++;
    assert (rsp_o.result === exp_rsp.result) else begin
      $display("[ERROR] %s: expected %h, actual %h", tag, exp_rsp.result, rsp_o.result);
      test_errors++;
    end
    if (is_cmp(op)) begin
      test_checks++;
      assert (rsp_o.cmp_flag === exp_rsp.cmp_flag) else begin
        $display("[ERROR] %s cmp_flag: expected %b, actual %b", tag, exp_rsp.cmp_flag,
                 rsp_o.cmp_flag);
        test_errors++;
      end
    end
    // keep req high a few extra cycles, response must hold
    repeat ($urandom_range(3)) begin
      @(posedge clk);
      #1;
    end
    test_checks++;
    assert (rsp_o.result === exp_rsp.result) else begin
      $display("[ERROR] %s hold: expected %h, actual %h", tag, exp_rsp.result, rsp_o.result);
      test_errors++;
    end
    req_i  = 1'b0;
    waited = 0;
    while (ack_o && waited < ACK_WAIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (ack_o) begin
      $display("%s: ack_o stayed high after req_i dropped", tag);
      test_errors++;
    end
  endtask

  // every op in every mode with random operands
  task automatic sweep(input alu_pkg::alu_op_e ops[], input int reps);
    foreach (modes[m]) begin
      for (int k = 0; k < reps; k++) begin
        foreach (ops[j]) begin
          run_txn(ops[j], modes[m], $urandom(), $urandom());
        end
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    $display("test %-12s %0d checks, %0d errors", test_name, test_checks, test_errors);
    num_tests++;
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [31:0] a;
    void'($urandom(78925));
    reset_i      = 1'b1;
    req_i        = 1'b0;
    req_data_i   = '0;
    num_tests    = 0;
    total_checks = 0;
    total_errors = 0;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    reset_i = 1'b0;

    start_test("reset");
    @(posedge clk);
    #1;
    test_checks++;
    assert (ack_o === 1'b0 && rsp_o === '0) else begin
      $display("[ERROR] reset: expected ack 0 rsp 0, actual ack %b rsp %h", ack_o, rsp_o);
      test_errors++;
    end
    finish_test();

    start_test("logic");
    sweep(logic_ops, 2);
    finish_test();

    start_test("add_sub");
    sweep(add_ops, 4);
    // carry and borrow must stop at each lane boundary
    for (int m = 1; m < 3; m++) begin
      run_txn(alu_pkg::ALU_ADD, modes[m], 32'hffff_ffff, 32'h0000_0001);
      run_txn(alu_pkg::ALU_SUB, modes[m], 32'h0000_0000, 32'h0000_0001);
    end
    finish_test();

    start_test("shift");
    sweep(shift_ops, 4);
    for (int k = 0; k < 4; k++) begin
      run_txn(alu_pkg::ALU_ROR, alu_pkg::VEC_MODE32, $urandom(), $urandom());
    end
    finish_test();

    start_test("compare");
    sweep(cmp_ops, 1);
    foreach (modes[m]) begin
      foreach (cmp_ops[j]) begin
        a = $urandom();
        run_txn(cmp_ops[j], modes[m], a, a);
        // signed and unsigned order disagree here
        run_txn(cmp_ops[j], modes[m], 32'h7f7f_7f7f, 32'h8080_8080);
      end
    end
    finish_test();

    start_test("min_max_abs");
    sweep(mm_ops, 2);
    foreach (modes[m]) begin
      foreach (mm_ops[j]) begin
        run_txn(mm_ops[j], modes[m], most_neg[m], $urandom());
      end
    end
    finish_test();

    $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             num_tests, total_checks, total_errors, DUT.u_props.fail_count);
    if (total_errors == 0 && DUT.u_props.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* test/alu_props.sv */
// four-phase handshake and reset checks on the ALU request port
// bound into alu_top
`timescale 1ns/10ps

module alu_props (
  input logic              clk,
  input logic              reset_i,
  input logic              req_i,
  input logic              ack_o,
  input alu_pkg::alu_rsp_t rsp_o
);

  // failures seen so far, read by the testbench at the end of the run
  int fail_count = 0;

  // one edge into reset the FSM is idle and ack stays low
  ack_low_in_reset: assert property (@(posedge clk) reset_i |=> !ack_o)
    else begin
      $error("ack_o high during reset");
      fail_count++;
    end

  // capture cycle, execute cycle, then ack
  ack_two_after_req: assert property (@(posedge clk) disable iff (reset_i)
    $rose(req_i) && !ack_o |-> ##1 !ack_o ##1 !ack_o ##1 ack_o)
    else begin
      $error("ack_o did not rise two cycles after req_i");
      fail_count++;
    end

  // response frozen through the ack phase
  rsp_stable_in_ack: assert property (@(posedge clk) disable iff (reset_i)
    ack_o && req_i |=> $stable(rsp_o))
    else begin
      $error("rsp_o changed while ack_o and req_i were high");
      fail_count++;
    end

  ack_falls_after_req: assert property (@(posedge clk) disable iff (reset_i)
    ack_o && !req_i |=> !ack_o)
    else begin
      $error("ack_o did not fall one cycle after req_i dropped");
      fail_count++;
    end

endmodule

bind alu_top alu_props u_props (
  .clk     (clk),
  .reset_i (reset_i),
  .req_i   (req_i),
  .ack_o   (ack_o),
  .rsp_o   (rsp_o)
);

/* hw/alu_top.sv */
// ALU top level: decode, adder, shifter, compare, result
`timescale 1ns/10ps

module alu_top (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              req_i,
  input  alu_pkg::alu_req_t req_data_i,
  output logic              ack_o,
  output alu_pkg::alu_rsp_t rsp_o
);

  logic                          capture;
  alu_pkg::alu_req_t             cur_req;
  alu_pkg::alu_ctrl_t            cur_ctrl;
  logic [alu_pkg::WORD_W-1:0]    add_result;
  logic [alu_pkg::WORD_W-1:0]    shift_result;
  logic [alu_pkg::NUM_LANES-1:0] cmp_lanes;
  logic [alu_pkg::WORD_W-1:0]    minmax_result;

  // request register and decoded controls
  alu_decode u_decode (
    .clk        (clk),
    .reset_i    (reset_i),
    .capture_i  (capture),
    .req_data_i (req_data_i),
    .cur_req_o  (cur_req),
    .cur_ctrl_o (cur_ctrl)
  );

  ////////////////////
  // execute units
  ////////////////////

  alu_adder u_adder (
    .req_i  (cur_req),
    .ctrl_i (cur_ctrl),
    .sum_o  (add_result)
  );

  alu_shifter u_shifter (
    .req_i   (cur_req),
    .ctrl_i  (cur_ctrl),
    .shift_o (shift_result)
  );

  // abs needs the adder output as its b side
  alu_compare u_compare (
    .req_i       (cur_req),
    .ctrl_i      (cur_ctrl),
    .sum_i       (add_result),
    .cmp_lanes_o (cmp_lanes),
    .minmax_o    (minmax_result)
  );

  alu_result u_result (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .ack_o       (ack_o),
    .capture_o   (capture),
    .cur_req_i   (cur_req),
    .ctrl_i      (cur_ctrl),
    .sum_i       (add_result),
    .shift_i     (shift_result),
    .cmp_lanes_i (cmp_lanes),
    .minmax_i    (minmax_result),
    .rsp_o       (rsp_o)
  );

endmodule

/* hw/alu_result.sv */
// four-phase req/ack FSM with capture strobe
// logic ops, result mux and response register
`timescale 1ns/10ps

module alu_result (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          req_i,
  output logic                          ack_o,
  output logic                          capture_o,
  input  alu_pkg::alu_req_t             cur_req_i,
  input  alu_pkg::alu_ctrl_t            ctrl_i,
  input  logic [alu_pkg::WORD_W-1:0]    sum_i,
  input  logic [alu_pkg::WORD_W-1:0]    shift_i,
  input  logic [alu_pkg::NUM_LANES-1:0] cmp_lanes_i,
  input  logic [alu_pkg::WORD_W-1:0]    minmax_i,
  output alu_pkg::alu_rsp_t             rsp_o
);

  alu_pkg::hs_state_e         state_q;
  alu_pkg::hs_state_e         state_d;
  logic                       capture_q;
  logic                       rsp_load;
  logic [alu_pkg::WORD_W-1:0] logic_res;
  logic [alu_pkg::WORD_W-1:0] result_d;

  ////////////////////
  // handshake FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      alu_pkg::HS_IDLE: if (req_i) state_d = alu_pkg::HS_BUSY;
      // wait out the capture cycle, then the operands are registered
      alu_pkg::HS_BUSY: if (!capture_q) state_d = alu_pkg::HS_DONE;
      alu_pkg::HS_DONE: if (!req_i) state_d = alu_pkg::HS_IDLE;
      default: state_d = alu_pkg::HS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= alu_pkg::HS_IDLE;
      capture_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // one pulse in the cycle after idle is left
      capture_q <= (state_q == alu_pkg::HS_IDLE) && req_i;
    end
  end

  assign capture_o = capture_q;
  assign ack_o     = (state_q == alu_pkg::HS_DONE);
  assign rsp_load  = (state_q == alu_pkg::HS_BUSY) && !capture_q;

  // bitwise ops, mode plays no part
  always_comb begin
    case (cur_req_i.op)
      alu_pkg::ALU_AND: logic_res = cur_req_i.operand_a & cur_req_i.operand_b;
      alu_pkg::ALU_OR:  logic_res = cur_req_i.operand_a | cur_req_i.operand_b;
      default:          logic_res = cur_req_i.operand_a ^ cur_req_i.operand_b;
    endcase
  end

  ////////////////////
  // result mux
  ////////////////////

  always_comb begin
    case (ctrl_i.sel)
      alu_pkg::RES_ADD:     result_d = sum_i;
      alu_pkg::RES_SHIFT:   result_d = shift_i;
      alu_pkg::RES_MINMAX:  result_d = minmax_i;
      // each lane bit fills its byte
      alu_pkg::RES_CMP_VEC: result_d = {{8{cmp_lanes_i[3]}}, {8{cmp_lanes_i[2]}},
                                        {8{cmp_lanes_i[1]}}, {8{cmp_lanes_i[0]}}};
      alu_pkg::RES_CMP_SCALAR: result_d = {{(alu_pkg::WORD_W-1){1'b0}}, cmp_lanes_i[3]};
      default:              result_d = logic_res;
    endcase
  end

  // response held through the ack phase
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_o <= '0;
    end else if (rsp_load) begin
      rsp_o.result   <= result_d;
      rsp_o.cmp_flag <= cmp_lanes_i[3];
    end
  end

endmodule

/* hw/alu_compare.sv */
// byte comparators chained by lane mode
// comparison opcode mapping and min/max/abs lane select
`timescale 1ns/10ps

module alu_compare (
  input  alu_pkg::alu_req_t             req_i,
  input  alu_pkg::alu_ctrl_t            ctrl_i,
  input  logic [alu_pkg::WORD_W-1:0]    sum_i,
  output logic [alu_pkg::NUM_LANES-1:0] cmp_lanes_o,
  output logic [alu_pkg::WORD_W-1:0]    minmax_o
);

  localparam int LW = alu_pkg::LANE_W;

  logic [alu_pkg::WORD_W-1:0]    cmp_b;
  logic [alu_pkg::NUM_LANES-1:0] eq_vec;
  logic [alu_pkg::NUM_LANES-1:0] gt_vec;
  logic [alu_pkg::NUM_LANES-1:0] is_eq;
  logic [alu_pkg::NUM_LANES-1:0] is_gt;
  logic [alu_pkg::NUM_LANES-1:0] sel_a;
  logic signed [LW:0]            lane_a;
  logic signed [LW:0]            lane_b;
  alu_pkg::vec_mode_e            mode_eff;

  // abs compares a against -a
  assign cmp_b    = (req_i.op == alu_pkg::ALU_ABS) ? sum_i : req_i.operand_b;
  // scalar set-less-than is always a whole-word compare
  assign mode_eff = (ctrl_i.sel == alu_pkg::RES_CMP_SCALAR) ? alu_pkg::VEC_MODE32 : req_i.mode;

  // per byte, the extra top bit makes signed and unsigned one compare
  always_comb begin
    lane_a = '0;
    lane_b = '0;
    for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
      lane_a    = {req_i.operand_a[LW*i+LW-1] & ctrl_i.cmp_signed[i], req_i.operand_a[LW*i +: LW]};
      lane_b    = {cmp_b[LW*i+LW-1] & ctrl_i.cmp_signed[i], cmp_b[LW*i +: LW]};
      eq_vec[i] = (lane_a == lane_b);
      gt_vec[i] = (lane_a > lane_b);
    end
  end

  ////////////////////
  // lane chaining
  ////////////////////

  always_comb begin
    case (mode_eff)
      alu_pkg::VEC_MODE8: begin
        is_eq = eq_vec;
        is_gt = gt_vec;
      end
      alu_pkg::VEC_MODE16: begin
        is_eq[1:0] = {2{eq_vec[1] & eq_vec[0]}};
        is_eq[3:2] = {2{eq_vec[3] & eq_vec[2]}};
        is_gt[1:0] = {2{gt_vec[1] | (eq_vec[1] & gt_vec[0])}};
        is_gt[3:2] = {2{gt_vec[3] | (eq_vec[3] & gt_vec[2])}};
      end
      default: begin
        // upper byte decides unless equal, then fall to the next one
        is_eq = {4{&eq_vec}};
        is_gt = {4{gt_vec[3] | (eq_vec[3] & (gt_vec[2] | (eq_vec[2] &
                  (gt_vec[1] | (eq_vec[1] & gt_vec[0])))))}};
      end
    endcase
  end

  always_comb begin
    case (req_i.op)
      alu_pkg::ALU_NE:  cmp_lanes_o = ~is_eq;
      alu_pkg::ALU_GES, alu_pkg::ALU_GEU: cmp_lanes_o = is_gt | is_eq;
      alu_pkg::ALU_LTS, alu_pkg::ALU_LTU,
      alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU: cmp_lanes_o = ~(is_gt | is_eq);
      default: cmp_lanes_o = is_eq;
    endcase
  end

  // max keeps a when a > b, min flips that
  assign sel_a = is_gt ^ {alu_pkg::NUM_LANES{ctrl_i.do_min}};

  always_comb begin
    for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
      minmax_o[LW*i +: LW] = sel_a[i] ? req_i.operand_a[LW*i +: LW] : cmp_b[LW*i +: LW];
    end
  end

endmodule

/* hw/alu_shifter.sv */
// lane-wise shifter: srl, sra, sll via bit reversal
// word rotate in 32-bit mode
`timescale 1ns/10ps

module alu_shifter (
  input  alu_pkg::alu_req_t          req_i,
  input  alu_pkg::alu_ctrl_t         ctrl_i,
  output logic [alu_pkg::WORD_W-1:0] shift_o
);

  logic [alu_pkg::WORD_W-1:0]   amt;
  logic [alu_pkg::WORD_W-1:0]   amt_left;
  logic [alu_pkg::WORD_W-1:0]   shift_in;
  logic [alu_pkg::WORD_W-1:0]   right_res;
  logic [2*alu_pkg::WORD_W-1:0] wide_in;
  logic [2*alu_pkg::WORD_W-1:0] wide_res;
  logic signed [16:0]           half_ext;
  logic signed [16:0]           half_res;
  logic signed [8:0]            byte_ext;
  logic signed [8:0]            byte_res;

  function automatic logic [alu_pkg::WORD_W-1:0] bit_rev(input logic [alu_pkg::WORD_W-1:0] x);
    logic [alu_pkg::WORD_W-1:0] r;
    for (int k = 0; k < alu_pkg::WORD_W; k++) begin
      r[k] = x[alu_pkg::WORD_W-1-k];
    end
    return r;
  endfunction

  // reversing the data also reverses which lane owns which amount
  always_comb begin
    case (req_i.mode)
      alu_pkg::VEC_MODE16: amt_left = {req_i.operand_b[15:0], req_i.operand_b[31:16]};
      alu_pkg::VEC_MODE8: amt_left = {req_i.operand_b[7:0], req_i.operand_b[15:8],
                                      req_i.operand_b[23:16], req_i.operand_b[31:24]};
      default: amt_left = req_i.operand_b;
    endcase
  end

  assign amt      = ctrl_i.shift_left ? amt_left : req_i.operand_b;
  assign shift_in = ctrl_i.shift_left ? bit_rev(req_i.operand_a) : req_i.operand_a;

  // rotate doubles the word so bits wrap into the low half
  assign wide_in  = ctrl_i.rotate ? {shift_in, shift_in} :
                    {{alu_pkg::WORD_W{ctrl_i.shift_arith & shift_in[31]}}, shift_in};
  assign wide_res = wide_in >> amt[4:0];

  ////////////////////
  // right shifter
  ////////////////////

  always_comb begin
    right_res = wide_res[alu_pkg::WORD_W-1:0];
    half_ext  = '0;
    half_res  = '0;
    byte_ext  = '0;
    byte_res  = '0;
    if (req_i.mode == alu_pkg::VEC_MODE16) begin
      for (int h = 0; h < 2; h++) begin
        half_ext = {ctrl_i.shift_arith & shift_in[16*h+15], shift_in[16*h +: 16]};
        half_res = half_ext >>> amt[16*h +: 4];
        right_res[16*h +: 16] = half_res[15:0];
      end
    end else if (req_i.mode == alu_pkg::VEC_MODE8) begin
      for (int b = 0; b < alu_pkg::NUM_LANES; b++) begin
        byte_ext = {ctrl_i.shift_arith & shift_in[8*b+7], shift_in[8*b +: 8]};
        byte_res = byte_ext >>> amt[8*b +: 3];
        right_res[8*b +: 8] = byte_res[7:0];
      end
    end
  end

  // undo the reversal for left shifts
  assign shift_o = ctrl_i.shift_left ? bit_rev(right_res) : right_res;

endmodule

/* hw/alu_adder.sv */
// partitioned adder, one word or two halves or four bytes
// subtract and negate share the lane carry injection
`timescale 1ns/10ps

module alu_adder (
  input  alu_pkg::alu_req_t       req_i,
  input  alu_pkg::alu_ctrl_t      ctrl_i,
  output logic [alu_pkg::WORD_W-1:0] sum_o
);

  // one separator bit below each byte lane
  localparam int STRIDE = alu_pkg::LANE_W + 1;
  localparam int EXT_W  = alu_pkg::WORD_W + alu_pkg::NUM_LANES;

  logic [alu_pkg::WORD_W-1:0]    op_a;
  logic [alu_pkg::WORD_W-1:0]    op_b;
  logic [EXT_W-1:0]              in_a;
  logic [EXT_W-1:0]              in_b;
  logic [EXT_W-1:0]              sum_ext;
  logic [alu_pkg::NUM_LANES-1:0] lane_cut;
  logic                          inject;

  // abs: ~a + 0 + 1, sub: a + ~b + 1
  assign op_a   = ctrl_i.negate_a ? ~req_i.operand_a : req_i.operand_a;
  assign op_b   = ctrl_i.negate_a ? '0 :
                  (ctrl_i.negate_b ? ~req_i.operand_b : req_i.operand_b);
  assign inject = ctrl_i.negate_a | ctrl_i.negate_b;

  // lane starts that block the carry, bit 0 is always a lane start
  always_comb begin
    case (req_i.mode)
      alu_pkg::VEC_MODE8:  lane_cut = 4'b1111;
      alu_pkg::VEC_MODE16: lane_cut = 4'b0101;
      default:             lane_cut = 4'b0001;
    endcase
  end

  // separator 1/0 passes the carry, 0/0 kills it, 1/1 injects a one
  always_comb begin
    for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
      in_a[STRIDE*i]                       = lane_cut[i] ? inject : 1'b1;
      in_b[STRIDE*i]                       = lane_cut[i] & inject;
      in_a[STRIDE*i+1 +: alu_pkg::LANE_W]  = op_a[alu_pkg::LANE_W*i +: alu_pkg::LANE_W];
      in_b[STRIDE*i+1 +: alu_pkg::LANE_W]  = op_b[alu_pkg::LANE_W*i +: alu_pkg::LANE_W];
    end
  end

  assign sum_ext = in_a + in_b;

  // drop the separator bits again
  always_comb begin
    for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
      sum_o[alu_pkg::LANE_W*i +: alu_pkg::LANE_W] = sum_ext[STRIDE*i+1 +: alu_pkg::LANE_W];
    end
  end

endmodule

/* hw/alu_decode.sv */
// request capture register
// opcode and mode decode into datapath controls
`timescale 1ns/10ps

module alu_decode (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              capture_i,
  input  alu_pkg::alu_req_t req_data_i,
  output alu_pkg::alu_req_t cur_req_o,
  output alu_pkg::alu_ctrl_t cur_ctrl_o
);

  alu_pkg::alu_ctrl_t              ctrl_d;
  logic [alu_pkg::NUM_LANES-1:0]   lane_signed;

  // sign bit position per lane for the incoming mode
  always_comb begin
    case (req_data_i.mode)
      alu_pkg::VEC_MODE8:  lane_signed = 4'b1111;
      alu_pkg::VEC_MODE16: lane_signed = 4'b1010;
      default:             lane_signed = 4'b1000;
    endcase
  end

  ////////////////////
  // control decode
  ////////////////////

  always_comb begin
    ctrl_d             = '0;
    ctrl_d.negate_b    = (req_data_i.op == alu_pkg::ALU_SUB);
    // abs runs 0 - a through the adder
    ctrl_d.negate_a    = (req_data_i.op == alu_pkg::ALU_ABS);
    ctrl_d.shift_left  = (req_data_i.op == alu_pkg::ALU_SLL);
    ctrl_d.shift_arith = (req_data_i.op == alu_pkg::ALU_SRA);
    ctrl_d.rotate      = (req_data_i.op == alu_pkg::ALU_ROR);
    ctrl_d.do_min      = (req_data_i.op == alu_pkg::ALU_MIN) ||
                         (req_data_i.op == alu_pkg::ALU_MINU);
    ctrl_d.sel         = alu_pkg::RES_LOGIC;

    case (req_data_i.op)
      alu_pkg::ALU_ADD, alu_pkg::ALU_SUB: ctrl_d.sel = alu_pkg::RES_ADD;
      alu_pkg::ALU_SLL, alu_pkg::ALU_SRL,
      alu_pkg::ALU_SRA, alu_pkg::ALU_ROR: ctrl_d.sel = alu_pkg::RES_SHIFT;
      alu_pkg::ALU_EQ, alu_pkg::ALU_NE,
      alu_pkg::ALU_LTU, alu_pkg::ALU_GEU: ctrl_d.sel = alu_pkg::RES_CMP_VEC;
      alu_pkg::ALU_LTS, alu_pkg::ALU_GES: begin
        ctrl_d.sel        = alu_pkg::RES_CMP_VEC;
        ctrl_d.cmp_signed = lane_signed;
      end
      alu_pkg::ALU_SLTU: ctrl_d.sel = alu_pkg::RES_CMP_SCALAR;
      alu_pkg::ALU_SLTS: begin
        // scalar compare ignores mode, only the word msb is a sign
        ctrl_d.sel        = alu_pkg::RES_CMP_SCALAR;
        ctrl_d.cmp_signed = 4'b1000;
      end
      alu_pkg::ALU_MINU, alu_pkg::ALU_MAXU: ctrl_d.sel = alu_pkg::RES_MINMAX;
      alu_pkg::ALU_MIN, alu_pkg::ALU_MAX, alu_pkg::ALU_ABS: begin
        ctrl_d.sel        = alu_pkg::RES_MINMAX;
        ctrl_d.cmp_signed = lane_signed;
      end
      default: ctrl_d.sel = alu_pkg::RES_LOGIC;
    endcase
  end

  // request payload, held until the next capture
  always_ff @(posedge clk) begin
    if (capture_i) begin
      cur_req_o <= req_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cur_ctrl_o <= '0;
    end else if (capture_i) begin
      cur_ctrl_o <= ctrl_d;
    end
  end

endmodule

/* hw/alu_pkg.sv */
// shared widths, opcode and mode encodings for the ALU
// request, decoded control and response structs
package alu_pkg;

  // datapath is fixed at one word with byte lanes
  localparam int WORD_W    = 32;
  localparam int LANE_W    = 8;
  localparam int NUM_LANES = WORD_W / LANE_W;

  // lane partitioning of the word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  typedef enum logic [4:0] {
    // bitwise
    ALU_AND  = 5'b00000,
    ALU_OR   = 5'b00001,
    ALU_XOR  = 5'b00010,
    // partitioned adder
    ALU_ADD  = 5'b00100,
    ALU_SUB  = 5'b00101,
    // shifter
    ALU_SLL  = 5'b01000,
    ALU_SRL  = 5'b01001,
    ALU_SRA  = 5'b01010,
    ALU_ROR  = 5'b01011,
    // lane-wise comparisons
    ALU_EQ   = 5'b01100,
    ALU_NE   = 5'b01101,
    ALU_LTS  = 5'b10000,
    ALU_LTU  = 5'b10001,
    ALU_GES  = 5'b10010,
    ALU_GEU  = 5'b10011,
    // scalar set-less-than, always whole word
    ALU_SLTS = 5'b10100,
    ALU_SLTU = 5'b10101,
    // min / max / abs
    ALU_MIN  = 5'b11000,
    ALU_MINU = 5'b11001,
    ALU_MAX  = 5'b11010,
    ALU_MAXU = 5'b11011,
    ALU_ABS  = 5'b11100
  } alu_op_e;

  // which execute unit drives the result word
  typedef enum logic [2:0] {
    RES_LOGIC      = 3'd0,
    RES_ADD        = 3'd1,
    RES_SHIFT      = 3'd2,
    RES_CMP_VEC    = 3'd3,
    RES_CMP_SCALAR = 3'd4,
    RES_MINMAX     = 3'd5
  } res_sel_e;

  typedef enum logic [1:0] {
    HS_IDLE = 2'b00,
    HS_BUSY = 2'b01,
    HS_DONE = 2'b10
  } hs_state_e;

  typedef struct packed {
    alu_op_e           op;
    vec_mode_e         mode;
    logic [WORD_W-1:0] operand_a;
    logic [WORD_W-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic                 negate_b;
    logic                 negate_a;
    logic                 shift_left;
    logic                 shift_arith;
    logic                 rotate;
    logic [NUM_LANES-1:0] cmp_signed;
    logic                 do_min;
    res_sel_e             sel;
  } alu_ctrl_t;

  typedef struct packed {
    logic [WORD_W-1:0] result;
    logic              cmp_flag;
  } alu_rsp_t;

endpackage
